//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the cache bank simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cache_bank_tb -f sim.f -o sim_cache_bank
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_cache_bank > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

//--- sim.f
verilog/cache_cfg_pkg.sv
verilog/cache_msg_pkg.sv
verilog/bank_decode.sv
verilog/bank_execute.sv
verilog/miss_table.sv
verilog/bank_result.sv
verilog/cache_bank.sv
verif/cache_bank_assert.sv
verif/cache_bank_tb.sv

//--- verif/cache_bank_assert.sv
`timescale 1ns/1ns

module cache_bank_assert import cache_cfg_pkg::*, cache_msg_pkg::*; (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    core_rsp_valid,
    input logic                    core_rsp_ready,
    input core_rsp_t               core_rsp,
    input logic                    mem_req_valid,
    input logic                    mem_req_ready,
    input mem_req_t                mem_req,
    input logic                    mem_rsp_valid,
    input logic                    mem_rsp_ready,
    input miss_id_t                mem_rsp_id,
    input logic                    stall,
    input logic [MISS_ENTRIES-1:0] ent_valid
);

    core_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp))
        else $error("core_rsp changed while waiting for ready");

    mem_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req changed while waiting for ready");

    // Fill must match an outstanding miss
    fill_allocated: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_valid && mem_rsp_ready |-> ent_valid[mem_rsp_id])
        else $error("fill for an id that is not allocated");

    stall_blocks_fill: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> !mem_rsp_ready)
        else $error("mem_rsp_ready high during stall");

endmodule

bind cache_bank cache_bank_assert u_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .core_rsp_valid (core_rsp_valid),
    .core_rsp_ready (core_rsp_ready),
    .core_rsp       (core_rsp),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req),
    .mem_rsp_valid  (mem_rsp_valid),
    .mem_rsp_ready  (mem_rsp_ready),
    .mem_rsp_id     (mem_rsp.id),
    .stall          (stall),
    .ent_valid      (u_miss_table.ent_valid)
);

//--- verif/cache_bank_tb.sv
`timescale 1ns/1ns

module cache_bank_tb import cache_cfg_pkg::*, cache_msg_pkg::*;;

    localparam int MAX_OPS    = 64;
    localparam int FILL_DELAY = 6;

    logic      clk = 1'b0;
    logic      rst_n = 1'b0;
    logic      core_req_valid = 1'b0;
    core_req_t core_req = '0;
    logic      core_req_ready;
    logic      core_rsp_valid;
    core_rsp_t core_rsp;
    logic      core_rsp_ready = 1'b0;
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      mem_req_ready = 1'b1;
    logic      mem_rsp_valid = 1'b0;
    mem_rsp_t  mem_rsp = '0;
    logic      mem_rsp_ready;

    logic [16:0] lfsr_state = 17'd99445;
    int unsigned cyc = 0;
    int unsigned limit = 100000;

    // Trace contents
    int        n_ops;
    logic [1:0] op_kind [MAX_OPS];
    core_req_t op_req [MAX_OPS];
    word_t     op_exp [MAX_OPS];

    // Scoreboard
    core_rsp_t   exp_rsp [16];
    int unsigned issued_cnt [16];
    int unsigned answered_cnt [16];
    int unsigned issued_total = 0;
    int unsigned answered_total = 0;
    mem_req_t    wr_exp [MAX_OPS];
    int unsigned wr_issued = 0;
    int unsigned wr_seen = 0;
    int unsigned mem_reads = 0;

    // Memory model
    word_t       mem_words [1 << (LINE_ADDR_BITS + 2)];
    line_data_t  fill_line [MISS_ENTRIES];
    int unsigned fill_cyc [MISS_ENTRIES];
    int unsigned fill_req_cnt [MISS_ENTRIES];
    int unsigned fill_sent_cnt [MISS_ENTRIES];
    int unsigned rsp_sent = 0;
    int unsigned rsp_accepted = 0;

    cache_bank u_cache_bank (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    // x^17 + x^14 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[16] ^ lfsr_state[13];
        lfsr_state = {lfsr_state[15:0], fb};
        return fb;
    endfunction

    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] e,
                                   input logic [31:0] a);
        $display("** Error: time %0t signal %s expected %h got %h", $time, name, e, a);
        fail_run();
    endtask

    task automatic check_flag(input string name, input logic e, input logic a);
        if (a !== e) begin
            report_mismatch(name, 32'(e), 32'(a));
        end
    endtask

    task automatic check_core_rsp(input core_rsp_t e, input core_rsp_t a);
        if (a.tag !== e.tag) begin
            report_mismatch("core_rsp.tag", 32'(e.tag), 32'(a.tag));
        end
        if (a.data !== e.data) begin
            report_mismatch("core_rsp.data", e.data, a.data);
        end
    endtask

    // Write id carries no meaning
    task automatic check_mem_req(input mem_req_t e, input mem_req_t a);
        if (a.rw !== e.rw) begin
            report_mismatch("mem_req.rw", 32'(e.rw), 32'(a.rw));
        end
        if (a.addr !== e.addr) begin
            report_mismatch("mem_req.addr", 32'(e.addr), 32'(a.addr));
        end
        if (a.wsel !== e.wsel) begin
            report_mismatch("mem_req.wsel", 32'(e.wsel), 32'(a.wsel));
        end
        if (a.byteen !== e.byteen) begin
            report_mismatch("mem_req.byteen", 32'(e.byteen), 32'(a.byteen));
        end
        if (a.data !== e.data) begin
            report_mismatch("mem_req.data", e.data, a.data);
        end
    endtask

    task automatic read_trace();
        int    fd;
        int    n;
        string line;
        string op_s;
        word_t f_addr;
        word_t f_wsel;
        word_t f_be;
        word_t f_data;
        word_t f_tag;
        word_t f_exp;
        fd = $fopen("verif/cache_bank_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file");
            fail_run();
        end
        n_ops = 0;
        while (!$feof(fd) && n_ops < MAX_OPS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h", op_s, f_addr, f_wsel, f_be,
                            f_data, f_tag, f_exp);
                if (n == 7) begin
                    op_kind[n_ops] = (op_s == "R") ? 2'd0 : (op_s == "W") ? 2'd1 : 2'd2;
                    op_req[n_ops]  = '{rw: (op_s == "W"), addr: line_addr_t'(f_addr),
                                       wsel: wsel_t'(f_wsel), byteen: byteen_t'(f_be),
                                       data: f_data, tag: core_tag_t'(f_tag)};
                    op_exp[n_ops]  = f_exp;
                    n_ops++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic send_req(input core_req_t req);
        @(negedge clk);
        core_req_valid = 1'b1;
        core_req       = req;
        @(posedge clk);
        while (!core_req_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_reads_done();
        while (answered_total != issued_total) begin
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            fail_run();
        end
    end

    // Response checks and memory side of the model
    always @(posedge clk) begin
        line_data_t ln;
        if (!rst_n) begin
            for (int i = 0; i < (1 << (LINE_ADDR_BITS + 2)); i++) begin
                mem_words[i] = word_t'(i);
            end
        end else begin
            if (core_rsp_valid && core_rsp_ready) begin
                if (issued_cnt[core_rsp.tag] == answered_cnt[core_rsp.tag]) begin
                    $display("Core response with tag %0h has no outstanding read", core_rsp.tag);
                    fail_run();
                end
                check_core_rsp(exp_rsp[core_rsp.tag], core_rsp);
                answered_cnt[core_rsp.tag] = answered_cnt[core_rsp.tag] + 1;
                answered_total = answered_total + 1;
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.rw) begin
                    if (wr_seen == wr_issued) begin
                        $display("Memory write appeared with no write request pending");
                        fail_run();
                    end
                    check_mem_req(wr_exp[wr_seen], mem_req);
                    wr_seen = wr_seen + 1;
                    for (int b = 0; b < 4; b++) begin
                        if (mem_req.byteen[b]) begin
                            mem_words[{mem_req.addr, mem_req.wsel}][b*8 +: 8] =
                                mem_req.data[b*8 +: 8];
                        end
                    end
                end else begin
                    mem_reads = mem_reads + 1;
                    for (int w = 0; w < WORDS_PER_LINE; w++) begin
                        ln[w*32 +: 32] = mem_words[{mem_req.addr, wsel_t'(w)}];
                    end
                    fill_line[mem_req.id]    = ln;
                    fill_cyc[mem_req.id]     = cyc;
                    fill_req_cnt[mem_req.id] = fill_req_cnt[mem_req.id] + 1;
                end
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                rsp_accepted = rsp_accepted + 1;
            end
        end
    end

    // Fill return in random order, and random core_rsp_ready
    always @(negedge clk) begin
        miss_id_t pick;
        if (rst_n) begin
            core_rsp_ready = lfsr_bit();
            if (mem_rsp_valid && rsp_accepted == rsp_sent) begin
                mem_rsp_valid = 1'b0;
            end
            if (!mem_rsp_valid) begin
                pick[1] = lfsr_bit();
                pick[0] = lfsr_bit();
                if (fill_req_cnt[pick] != fill_sent_cnt[pick]
                    && cyc >= fill_cyc[pick] + FILL_DELAY) begin
                    mem_rsp       = '{id: pick, line: fill_line[pick]};
                    mem_rsp_valid = 1'b1;
                    fill_sent_cnt[pick] = fill_sent_cnt[pick] + 1;
                    rsp_sent = rsp_sent + 1;
                end
            end
        end
    end

    initial begin
        int unsigned exp_reads;
        exp_reads = 0;
        read_trace();
        limit = 40 * n_ops + 200;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_flag("core_rsp_valid", 1'b0, core_rsp_valid);
        check_flag("mem_req_valid", 1'b0, mem_req_valid);
        for (int i = 0; i < n_ops; i++) begin
            if (op_kind[i] == 2'd0) begin
                send_req(op_req[i]);
                exp_rsp[op_req[i].tag]    = '{tag: op_req[i].tag, data: op_exp[i]};
                issued_cnt[op_req[i].tag] = issued_cnt[op_req[i].tag] + 1;
                issued_total = issued_total + 1;
            end else if (op_kind[i] == 2'd1) begin
                // Earlier fills must land before a write to keep the model exact
                wait_reads_done();
                send_req(op_req[i]);
                wr_exp[wr_issued] = '{rw: 1'b1, addr: op_req[i].addr, id: '0,
                                      wsel: op_req[i].wsel, byteen: op_req[i].byteen,
                                      data: op_req[i].data};
                wr_issued = wr_issued + 1;
            end else begin
                exp_reads = op_exp[i];
            end
            @(negedge clk);
            core_req_valid = 1'b0;
        end
        wait_reads_done();
        while (wr_seen != wr_issued) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (mem_reads != exp_reads) begin
            report_mismatch("memory read count", exp_reads, mem_reads);
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- verif/cache_bank_trace.txt
# op addr wsel byteen data tag expected, all hex
# R read, W write, E end with the expected number of memory reads in the last column
R 010 1 f 00000000 1 00000041
R 023 2 f 00000000 2 0000008e
R 1a5 3 f 00000000 3 00000697
R 3c7 0 f 00000000 4 00000f1c
W 0b8 0 f deadbeef 0 00000000
R 010 0 f 00000000 5 00000040
R 023 2 f 00000000 6 0000008e
R 0b8 0 f 00000000 7 deadbeef
W 010 1 3 12345678 0 00000000
R 010 1 f 00000000 9 00005678
R 0b8 1 f 00000000 a 000002e1
R 1a5 3 f 00000000 b 00000697
W 023 3 8 a5000000 0 00000000
R 023 3 f 00000000 1 a500008f
R 20a 2 f 00000000 2 0000082a
R 311 0 f 00000000 3 00000c44
R 4fe 1 f 00000000 4 000013f9
R 7cd 3 f 00000000 5 00001f37
R 56c 2 f 00000000 6 000015b2
W 0e9 2 f 0badf00d 0 00000000
R 20a 0 f 00000000 7 00000828
R 7cd 0 f 00000000 8 00001f34
R 0e9 2 f 00000000 9 0badf00d
E 000 0 0 00000000 0 0000000b

//--- verilog/bank_decode.sv
`timescale 1ns/1ns

module bank_decode import cache_cfg_pkg::*, cache_msg_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       core_req_valid,
    input  core_req_t  core_req,
    output logic       core_req_ready,
    input  logic       mem_rsp_valid,
    input  mem_rsp_t   mem_rsp,
    output logic       mem_rsp_ready,
    input  logic       stall,
    input  logic       mreq_room,
    input  logic       miss_full,
    input  miss_id_t   miss_free_id,
    output logic       miss_alloc,
    input  line_addr_t fill_addr,
    input  wsel_t      fill_wsel,
    input  core_tag_t  fill_tag,
    output miss_id_t   fill_id,
    output stage_op_t  op
);

    core_req_t buf_req;
    core_req_t cur_req;
    logic      buf_valid;
    logic      buf_next;
    logic      core_fire;
    logic      cur_valid;
    logic      take_core;
    logic      fill_take;
    stage_op_t op_d;
    stage_op_t op_q;
    logic      valid_q;

    // One-entry buffer bypassed when empty
    assign core_fire = core_req_valid && core_req_ready;
    assign cur_valid = buf_valid || core_fire;
    assign cur_req   = buf_valid ? buf_req : core_req;

    assign mem_rsp_ready = !stall;
    assign fill_take     = mem_rsp_valid && !stall;
    assign fill_id       = mem_rsp.id;

    // A read waits while the previous allocation is still being written
    assign take_core = cur_valid && !mem_rsp_valid && !stall && !miss_full && mreq_room
                       && (cur_req.rw || !miss_alloc);
    assign buf_next  = cur_valid && !take_core;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid      <= 1'b0;
            core_req_ready <= 1'b0;
            miss_alloc     <= 1'b0;
        end else begin
            buf_valid      <= buf_next;
            core_req_ready <= !buf_next;
            miss_alloc     <= take_core && !cur_req.rw;
        end
    end

    always_ff @(posedge clk) begin
        if (core_fire) begin
            buf_req <= core_req;
        end
    end

    always_comb begin
        op_d          = op_q;
        op_d.valid    = fill_take || take_core;
        op_d.is_fill  = fill_take;
        op_d.is_read  = !fill_take && !cur_req.rw;
        op_d.is_write = !fill_take && cur_req.rw;
        op_d.addr     = fill_take ? fill_addr : cur_req.addr;
        op_d.wsel     = fill_take ? fill_wsel : cur_req.wsel;
        op_d.byteen   = cur_req.byteen;
        op_d.data     = cur_req.data;
        op_d.line     = mem_rsp.line;
        op_d.tag      = fill_take ? fill_tag : cur_req.tag;
        op_d.id       = fill_take ? mem_rsp.id : miss_free_id;
    end

    // Stage 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= op_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            op_q <= op_d;
        end else if (miss_alloc) begin
            op_q.id <= miss_free_id;
        end
    end

    // Read id is fixed in the cycle its entry is written
    always_comb begin
        op       = op_q;
        op.valid = valid_q;
        if (miss_alloc) begin
            op.id = miss_free_id;
        end
    end

endmodule

//--- verilog/bank_execute.sv
`timescale 1ns/1ns

module bank_execute import cache_cfg_pkg::*, cache_msg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  stage_op_t op,
    input  logic      stall,
    output logic      release_valid,
    output miss_id_t  release_id,
    output exec_out_t result
);

    line_tag_t                      tag_mem  [NUM_LINES];
    line_data_t                     data_mem [NUM_LINES];
    logic [NUM_LINES-1:0]           line_valid;

    line_idx_t                      idx;
    line_tag_t                      ltag;
    logic                           hit;
    logic                           do_read;
    logic                           do_write;
    logic                           do_fill;
    word_t [WORDS_PER_LINE-1:0]     rd_words;
    word_t [WORDS_PER_LINE-1:0]     fill_words;
    word_t [WORDS_PER_LINE-1:0]     wr_words;
    exec_out_t                      res_d;
    exec_out_t                      res_q;
    logic                           rsp_q;
    logic                           mreq_q;
    logic                           rel_q;

    assign idx  = op.addr[$bits(line_idx_t)-1:0];
    assign ltag = op.addr[LINE_ADDR_BITS-1:$bits(line_idx_t)];
    assign hit  = line_valid[idx] && (tag_mem[idx] == ltag);

    assign do_read  = op.valid && op.is_read;
    assign do_write = op.valid && op.is_write;
    assign do_fill  = op.valid && op.is_fill;

    assign rd_words   = data_mem[idx];
    assign fill_words = op.line;

    // Byte merge for a write hit
    always_comb begin
        wr_words = rd_words;
        for (int b = 0; b < $bits(byteen_t); b++) begin
            if (op.byteen[b]) begin
                wr_words[op.wsel][b*8 +: 8] = op.data[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_valid <= '0;
        end else if (!stall && do_fill) begin
            line_valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (do_fill) begin
                tag_mem[idx]  <= ltag;
                data_mem[idx] <= op.line;
            end else if (do_write && hit) begin
                data_mem[idx] <= wr_words;
            end
        end
    end

    // Fill answers the waiting read straight from the line
    always_comb begin
        res_d           = res_q;
        res_d.rsp_push  = do_fill || (do_read && hit);
        res_d.mreq_push = (do_read && !hit) || do_write;
        res_d.mreq_rw   = do_write;
        res_d.addr      = op.addr;
        res_d.id        = op.id;
        res_d.wsel      = op.wsel;
        res_d.byteen    = op.byteen;
        res_d.tag       = op.tag;
        if (do_write) begin
            res_d.data = op.data;
        end else if (do_fill) begin
            res_d.data = fill_words[op.wsel];
        end else begin
            res_d.data = rd_words[op.wsel];
        end
    end

    // Stage 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_q  <= 1'b0;
            mreq_q <= 1'b0;
            rel_q  <= 1'b0;
        end else if (!stall) begin
            rsp_q  <= res_d.rsp_push;
            mreq_q <= res_d.mreq_push;
            rel_q  <= do_fill || (do_read && hit);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            res_q <= res_d;
        end
    end

    always_comb begin
        result           = res_q;
        result.rsp_push  = rsp_q;
        result.mreq_push = mreq_q;
    end

    // Entry is freed when stage 1 moves on
    assign release_valid = rel_q && !stall;
    assign release_id    = res_q.id;

endmodule

//--- verilog/bank_result.sv
`timescale 1ns/1ns

module bank_result import cache_cfg_pkg::*, cache_msg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  exec_out_t result,
    output logic      stall,
    output logic      mreq_room,
    output logic      core_rsp_valid,
    output core_rsp_t core_rsp,
    input  logic      core_rsp_ready,
    output logic      mem_req_valid,
    output mem_req_t  mem_req,
    input  logic      mem_req_ready
);

    typedef logic [$clog2(CRSQ_DEPTH)-1:0]   crsq_ptr_t;
    typedef logic [$clog2(CRSQ_DEPTH+1)-1:0] crsq_cnt_t;
    typedef logic [$clog2(MREQ_DEPTH)-1:0]   mreq_ptr_t;
    typedef logic [$clog2(MREQ_DEPTH+1)-1:0] mreq_cnt_t;

    core_rsp_t crsq_mem [CRSQ_DEPTH];
    crsq_ptr_t crsq_wp;
    crsq_ptr_t crsq_rp;
    crsq_cnt_t crsq_cnt;
    logic      crsq_push;
    logic      crsq_pop;
    logic      crsq_full;

    mem_req_t  mreq_mem [MREQ_DEPTH];
    mreq_ptr_t mreq_wp;
    mreq_ptr_t mreq_rp;
    mreq_cnt_t mreq_cnt;
    logic      mreq_push;
    logic      mreq_pop;

    assign crsq_full = (crsq_cnt == crsq_cnt_t'(CRSQ_DEPTH));
    assign stall     = result.rsp_push && crsq_full;
    assign crsq_push = result.rsp_push && !stall;
    assign crsq_pop  = core_rsp_valid && core_rsp_ready;
    assign mreq_push = result.mreq_push && !stall;
    assign mreq_pop  = mem_req_valid && mem_req_ready;

    // Stage 1 push counts as taken so stage 0 and a new request always fit
    assign mreq_room = result.mreq_push ? (mreq_cnt < mreq_cnt_t'(MREQ_DEPTH - 2))
                                        : (mreq_cnt < mreq_cnt_t'(MREQ_DEPTH - 1));

    // Core response FIFO
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crsq_wp  <= '0;
            crsq_rp  <= '0;
            crsq_cnt <= '0;
        end else begin
            if (crsq_push) begin
                crsq_wp <= (crsq_wp == crsq_ptr_t'(CRSQ_DEPTH - 1)) ? '0 : crsq_wp + 1'b1;
            end
            if (crsq_pop) begin
                crsq_rp <= (crsq_rp == crsq_ptr_t'(CRSQ_DEPTH - 1)) ? '0 : crsq_rp + 1'b1;
            end
            if (crsq_push && !crsq_pop) begin
                crsq_cnt <= crsq_cnt + 1'b1;
            end else if (!crsq_push && crsq_pop) begin
                crsq_cnt <= crsq_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (crsq_push) begin
            crsq_mem[crsq_wp] <= '{tag: result.tag, data: result.data};
        end
    end

    assign core_rsp_valid = (crsq_cnt != '0);
    assign core_rsp       = crsq_mem[crsq_rp];

    // Memory request FIFO
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mreq_wp  <= '0;
            mreq_rp  <= '0;
            mreq_cnt <= '0;
        end else begin
            if (mreq_push) begin
                mreq_wp <= (mreq_wp == mreq_ptr_t'(MREQ_DEPTH - 1)) ? '0 : mreq_wp + 1'b1;
            end
            if (mreq_pop) begin
                mreq_rp <= (mreq_rp == mreq_ptr_t'(MREQ_DEPTH - 1)) ? '0 : mreq_rp + 1'b1;
            end
            if (mreq_push && !mreq_pop) begin
                mreq_cnt <= mreq_cnt + 1'b1;
            end else if (!mreq_push && mreq_pop) begin
                mreq_cnt <= mreq_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mreq_push) begin
            mreq_mem[mreq_wp] <= '{rw: result.mreq_rw, addr: result.addr, id: result.id,
                                   wsel: result.wsel, byteen: result.byteen,
                                   data: result.data};
        end
    end

    assign mem_req_valid = (mreq_cnt != '0);
    assign mem_req       = mreq_mem[mreq_rp];

endmodule

//--- verilog/cache_bank.sv
`timescale 1ns/1ns

module cache_bank import cache_cfg_pkg::*, cache_msg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      core_req_valid,
    input  core_req_t core_req,
    output logic      core_req_ready,
    output logic      core_rsp_valid,
    output core_rsp_t core_rsp,
    input  logic      core_rsp_ready,
    output logic      mem_req_valid,
    output mem_req_t  mem_req,
    input  logic      mem_req_ready,
    input  logic      mem_rsp_valid,
    input  mem_rsp_t  mem_rsp,
    output logic      mem_rsp_ready
);

    stage_op_t  stage_op;
    exec_out_t  exec_res;
    logic       stall;
    logic       mreq_room;
    logic       miss_alloc;
    logic       miss_full;
    miss_id_t   miss_free_id;
    miss_id_t   fill_id;
    line_addr_t fill_addr;
    wsel_t      fill_wsel;
    core_tag_t  fill_tag;
    logic       release_valid;
    miss_id_t   release_id;

    bank_decode u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .mem_rsp_ready  (mem_rsp_ready),
        .stall          (stall),
        .mreq_room      (mreq_room),
        .miss_full      (miss_full),
        .miss_free_id   (miss_free_id),
        .miss_alloc     (miss_alloc),
        .fill_addr      (fill_addr),
        .fill_wsel      (fill_wsel),
        .fill_tag       (fill_tag),
        .fill_id        (fill_id),
        .op             (stage_op)
    );

    bank_execute u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .op            (stage_op),
        .stall         (stall),
        .release_valid (release_valid),
        .release_id    (release_id),
        .result        (exec_res)
    );

    // Allocation takes the read held in stage 0
    miss_table u_miss_table (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc         (miss_alloc),
        .alloc_addr    (stage_op.addr),
        .alloc_wsel    (stage_op.wsel),
        .alloc_tag     (stage_op.tag),
        .free_id       (miss_free_id),
        .full          (miss_full),
        .lookup_id     (fill_id),
        .lookup_addr   (fill_addr),
        .lookup_wsel   (fill_wsel),
        .lookup_tag    (fill_tag),
        .release_valid (release_valid),
        .release_id    (release_id)
    );

    bank_result u_result (
        .clk            (clk),
        .rst_n          (rst_n),
        .result         (exec_res),
        .stall          (stall),
        .mreq_room      (mreq_room),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready)
    );

endmodule

//--- verilog/cache_cfg_pkg.sv
package cache_cfg_pkg;

    // Bank geometry
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_LINES      = 16;
    localparam int LINE_ADDR_BITS = 12;

    // Queue and table sizes
    localparam int MISS_ENTRIES   = 4;
    localparam int CRSQ_DEPTH     = 4;
    localparam int MREQ_DEPTH     = 4;

    typedef logic [31:0]                                     word_t;
    typedef logic [WORDS_PER_LINE*$bits(word_t)-1:0]         line_data_t;
    typedef logic [LINE_ADDR_BITS-1:0]                       line_addr_t;
    // Set index is the low part of the line address
    typedef logic [$clog2(NUM_LINES)-1:0]                    line_idx_t;
    typedef logic [LINE_ADDR_BITS-$clog2(NUM_LINES)-1:0]     line_tag_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0]               wsel_t;
    typedef logic [$bits(word_t)/8-1:0]                      byteen_t;
    typedef logic [3:0]                                      core_tag_t;
    typedef logic [$clog2(MISS_ENTRIES)-1:0]                 miss_id_t;

endpackage

//--- verilog/cache_msg_pkg.sv
package cache_msg_pkg;

    import cache_cfg_pkg::*;

    typedef struct packed {
        logic       rw;
        line_addr_t addr;
        wsel_t      wsel;
        byteen_t    byteen;
        word_t      data;
        core_tag_t  tag;
    } core_req_t;

    typedef struct packed {
        core_tag_t tag;
        word_t     data;
    } core_rsp_t;

    typedef struct packed {
        logic       rw;
        line_addr_t addr;
        miss_id_t   id;
        wsel_t      wsel;
        byteen_t    byteen;
        word_t      data;
    } mem_req_t;

    typedef struct packed {
        miss_id_t   id;
        line_data_t line;
    } mem_rsp_t;

    // Decode to execute
    typedef struct packed {
        logic       valid;
        logic       is_fill;
        logic       is_read;
        logic       is_write;
        line_addr_t addr;
        wsel_t      wsel;
        byteen_t    byteen;
        word_t      data;
        line_data_t line;
        core_tag_t  tag;
        miss_id_t   id;
    } stage_op_t;

    // Execute to result
    // Data carries the read word or the write data
    typedef struct packed {
        logic       rsp_push;
        logic       mreq_push;
        logic       mreq_rw;
        line_addr_t addr;
        miss_id_t   id;
        wsel_t      wsel;
        byteen_t    byteen;
        word_t      data;
        core_tag_t  tag;
    } exec_out_t;

endpackage

//--- verilog/miss_table.sv
`timescale 1ns/1ns

module miss_table import cache_cfg_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       alloc,
    input  line_addr_t alloc_addr,
    input  wsel_t      alloc_wsel,
    input  core_tag_t  alloc_tag,
    output miss_id_t   free_id,
    output logic       full,
    input  miss_id_t   lookup_id,
    output line_addr_t lookup_addr,
    output wsel_t      lookup_wsel,
    output core_tag_t  lookup_tag,
    input  logic       release_valid,
    input  miss_id_t   release_id
);

    logic [MISS_ENTRIES-1:0] ent_valid;
    line_addr_t              ent_addr [MISS_ENTRIES];
    wsel_t                   ent_wsel [MISS_ENTRIES];
    core_tag_t               ent_tag  [MISS_ENTRIES];

    // Lowest free entry wins
    always_comb begin
        free_id = '0;
        for (int i = MISS_ENTRIES - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_id = miss_id_t'(i);
            end
        end
    end

    assign full = &ent_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_valid <= '0;
        end else begin
            if (alloc) begin
                ent_valid[free_id] <= 1'b1;
            end
            if (release_valid) begin
                ent_valid[release_id] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_addr[free_id] <= alloc_addr;
            ent_wsel[free_id] <= alloc_wsel;
            ent_tag[free_id]  <= alloc_tag;
        end
    end

    assign lookup_addr = ent_addr[lookup_id];
    assign lookup_wsel = ent_wsel[lookup_id];
    assign lookup_tag  = ent_tag[lookup_id];

endmodule
